//--- vlog.f
hw/axil_pkg.sv
hw/axil_slave.sv
hw/reg_bank.sv
hw/axil_reg_top.sv
verif/axil_reg_tb.sv

//--- Makefile
# Verilator flow for the AXI4-Lite register block
# Override from the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= axil_reg_tb
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
# Extra lint options, e.g. -Wall
LINT_FLAGS ?=

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Result taken from the log, not from the exit status
sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || { echo "Simulation ended without a result"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/axil_reg_tb.sv
/*
  Self-checking testbench for the AXI4-Lite register block, one transaction at a time.
  Valid, bready and rready get random 0..3 cycle delays from a fixed seed.
  Inputs change on the falling clock edge, and outputs are sampled there too.
*/
module axil_reg_tb;

  import axil_pkg::*;

  localparam int unsigned SEED = 32'h6970;
  localparam int N_RT   = 200;
  localparam int N_STRB = 100;
  localparam int N_BAD  = 40;
  localparam int N_ID   = 4;
  localparam int N_PAIR = 20;
  // AXI transactions over all tests, reads and writes counted apart
  localparam int TOTAL_TXN = 7 + 2 * (N_RT + N_STRB + N_BAD + N_ID + N_PAIR) + NUM_RW_REGS;
  localparam int TIMEOUT_CYCLES = 5 + 40 * TOTAL_TXN;

  logic  clk;
  logic  rst;
  logic  awvalid;
  addr_t awaddr;
  logic  awready;
  logic  wvalid;
  data_t wdata;
  strb_t wstrb;
  logic  wready;
  logic  bvalid;
  resp_t bresp;
  logic  bready;
  logic  arvalid;
  addr_t araddr;
  logic  arready;
  logic  rvalid;
  data_t rdata;
  resp_t rresp;
  logic  rready;

  // Register model
  data_t model_regs [NUM_RW_REGS];

  int checks;
  int errors;
  int unsigned cycles;

  axil_reg_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .i_awvalid (awvalid),
    .i_awaddr  (awaddr),
    .o_awready (awready),
    .i_wvalid  (wvalid),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .o_wready  (wready),
    .o_bvalid  (bvalid),
    .o_bresp   (bresp),
    .i_bready  (bready),
    .i_arvalid (arvalid),
    .i_araddr  (araddr),
    .o_arready (arready),
    .o_rvalid  (rvalid),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .i_rready  (rready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit from the transaction count
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, a handshake never completed", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("Mismatch at %0t: %s expected 0x%08h actual 0x%08h",
               $time, name, expected, actual);
      errors++;
    end
  endtask

  // Valid only if word aligned and below the end of the map
  function automatic logic addr_in_map(input addr_t addr);
    return (addr[1:0] == 2'b00) && (addr < MAP_END);
  endfunction

  function automatic resp_t model_write(input addr_t addr, input data_t data,
                                        input strb_t strb);
    logic [2:0] idx;
    idx = addr[4:2];
    if (!addr_in_map(addr)) return RESP_DECERR;
    // ID write dropped, still OKAY
    if (addr == ID_ADDR) return RESP_OKAY;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) model_regs[idx][8*b +: 8] = data[8*b +: 8];
    end
    return RESP_OKAY;
  endfunction

  function automatic void model_read(input addr_t addr, output data_t data,
                                     output resp_t resp);
    logic [2:0] idx;
    idx = addr[4:2];
    if (!addr_in_map(addr)) begin
      data = '0;
      resp = RESP_DECERR;
    end else begin
      data = (addr == ID_ADDR) ? ID_VALUE : model_regs[idx];
      resp = RESP_OKAY;
    end
  endfunction

  function automatic addr_t rand_reg_addr();
    return addr_t'(4 * $urandom_range(NUM_RW_REGS - 1, 0));
  endfunction

  // Unaligned in map, just past the map, or far out
  function automatic addr_t rand_bad_addr();
    addr_t addr;
    case ($urandom_range(2, 0))
      0: addr = addr_t'(4 * $urandom_range(6, 0) + $urandom_range(3, 1));
      1: addr = MAP_END + addr_t'($urandom_range(255, 0));
      default: addr = addr_t'($urandom) | 32'h8000_0000;
    endcase
    return addr;
  endfunction

  // Valid raised at a falling edge, dropped one edge after ready was seen
  task automatic accept_aw();
    while (!awready) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
  endtask

  task automatic accept_ar();
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic send_w(input data_t data, input strb_t strb);
    repeat ($urandom_range(3, 0)) @(negedge clk);
    wvalid = 1'b1;
    wdata  = data;
    wstrb  = strb;
    while (!wready) @(negedge clk);
    @(negedge clk);
    wvalid = 1'b0;
  endtask

  // Response held back for a random time, payload must not move
  task automatic take_b(output resp_t resp);
    int hold;
    hold = $urandom_range(3, 0);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    // Bridge busy, no address or data taken
    check_value("awready (busy)", 32'h0, 32'(awready));
    check_value("arready (busy)", 32'h0, 32'(arready));
    check_value("wready (busy)", 32'h0, 32'(wready));
    repeat (hold) begin
      @(negedge clk);
      checks++;
      assert (bvalid) else begin
        $display("At %0t bvalid dropped while bready was low", $time);
        errors++;
      end
      check_value("bresp (held)", 32'(resp), 32'(bresp));
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic take_r(output data_t data, output resp_t resp);
    int hold;
    hold = $urandom_range(3, 0);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    // Bridge busy, no address taken
    check_value("awready (busy)", 32'h0, 32'(awready));
    check_value("arready (busy)", 32'h0, 32'(arready));
    repeat (hold) begin
      @(negedge clk);
      checks++;
      assert (rvalid) else begin
        $display("At %0t rvalid dropped while rready was low", $time);
        errors++;
      end
      check_value("rdata (held)", data, rdata);
      check_value("rresp (held)", 32'(resp), 32'(rresp));
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                           output resp_t resp);
    repeat ($urandom_range(3, 0)) @(negedge clk);
    awvalid = 1'b1;
    awaddr  = addr;
    accept_aw();
    send_w(data, strb);
    take_b(resp);
  endtask

  task automatic axi_read(input addr_t addr, output data_t data, output resp_t resp);
    repeat ($urandom_range(3, 0)) @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    accept_ar();
    take_r(data, resp);
  endtask

  task automatic write_check(input addr_t addr, input data_t data, input strb_t strb);
    resp_t exp_resp;
    resp_t resp;
    exp_resp = model_write(addr, data, strb);
    axi_write(addr, data, strb, resp);
    check_value("bresp", 32'(exp_resp), 32'(resp));
  endtask

  task automatic read_check(input addr_t addr);
    data_t exp_data;
    resp_t exp_resp;
    data_t data;
    resp_t resp;
    model_read(addr, exp_data, exp_resp);
    axi_read(addr, data, resp);
    check_value("rdata", exp_data, data);
    check_value("rresp", 32'(exp_resp), 32'(resp));
  endtask

  // AW and AR raised together, the write must be served first
  task automatic write_read_pair(input addr_t addr, input data_t data);
    resp_t exp_bresp;
    data_t exp_data;
    resp_t exp_rresp;
    resp_t got_bresp;
    data_t got_data;
    resp_t got_rresp;
    exp_bresp = model_write(addr, data, 4'hF);
    model_read(addr, exp_data, exp_rresp);
    repeat ($urandom_range(3, 0)) @(negedge clk);
    awvalid = 1'b1;
    awaddr  = addr;
    arvalid = 1'b1;
    araddr  = addr;
    accept_aw();
    send_w(data, 4'hF);
    take_b(got_bresp);
    accept_ar();
    take_r(got_data, got_rresp);
    check_value("bresp", 32'(exp_bresp), 32'(got_bresp));
    check_value("rdata", exp_data, got_data);
    check_value("rresp", 32'(exp_rresp), 32'(got_rresp));
  endtask

  task automatic report_test(input string name, input int chk0, input int err0);
    $display("Test %s finished: %0d checks, %0d errors",
             name, checks - chk0, errors - err0);
  endtask

  task automatic reset_reads();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < NUM_RW_REGS; i++) read_check(addr_t'(4 * i));
    read_check(ID_ADDR);
    report_test("reset_reads", c0, e0);
  endtask

  task automatic round_trip();
    int    c0;
    int    e0;
    addr_t a;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_RT; i++) begin
      a = rand_reg_addr();
      write_check(a, $urandom, 4'hF);
      read_check(a);
    end
    report_test("round_trip", c0, e0);
  endtask

  task automatic byte_strobe_merge();
    int    c0;
    int    e0;
    addr_t a;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_STRB; i++) begin
      a = rand_reg_addr();
      write_check(a, $urandom, strb_t'($urandom_range(15, 0)));
      read_check(a);
    end
    report_test("byte_strobe_merge", c0, e0);
  endtask

  task automatic invalid_access();
    int    c0;
    int    e0;
    addr_t a;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_BAD; i++) begin
      a = rand_bad_addr();
      write_check(a, $urandom, strb_t'($urandom_range(15, 0)));
      read_check(a);
    end
    // Nothing in the map may have moved
    for (int i = 0; i < NUM_RW_REGS; i++) read_check(addr_t'(4 * i));
    for (int i = 0; i < N_ID; i++) begin
      write_check(ID_ADDR, $urandom, 4'hF);
      read_check(ID_ADDR);
    end
    report_test("invalid_access", c0, e0);
  endtask

  task automatic write_before_read();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < N_PAIR; i++) write_read_pair(rand_reg_addr(), $urandom);
    report_test("write_before_read", c0, e0);
  endtask

  initial begin
    rst     = 1'b1;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    checks  = 0;
    errors  = 0;
    for (int i = 0; i < NUM_RW_REGS; i++) model_regs[i] = '0;
    void'($urandom(SEED));

    // Five rising edges in reset
    repeat (5) @(negedge clk);
    rst = 1'b0;

    reset_reads();
    round_trip();
    byte_strobe_merge();
    invalid_access();
    write_before_read();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- hw/axil_reg_top.sv
/*
  Register block with an AXI4-Lite slave port only.
  Latency depends on master back-pressure. bvalid or rvalid ends a transaction.
*/
module axil_reg_top (
  input  logic             clk,
  input  logic             rst,

  input  logic             i_awvalid,
  input  axil_pkg::addr_t  i_awaddr,
  output logic             o_awready,

  input  logic             i_wvalid,
  input  axil_pkg::data_t  i_wdata,
  input  axil_pkg::strb_t  i_wstrb,
  output logic             o_wready,

  output logic             o_bvalid,
  output axil_pkg::resp_t  o_bresp,
  input  logic             i_bready,

  input  logic             i_arvalid,
  input  axil_pkg::addr_t  i_araddr,
  output logic             o_arready,

  output logic             o_rvalid,
  output axil_pkg::data_t  o_rdata,
  output axil_pkg::resp_t  o_rresp,
  input  logic             i_rready
);

  import axil_pkg::*;

  // User side between bridge and bank
  addr_t   reg_addr;
  logic    wr_req;
  reg_wr_t wr;
  logic    wr_ack_stb;
  logic    wr_invalid;
  logic    rd_req;
  logic    rd_ack_stb;
  reg_rd_t rd;

  axil_slave slave0 (
    .clk          (clk),
    .rst          (rst),
    .i_awvalid    (i_awvalid),
    .i_awaddr     (i_awaddr),
    .o_awready    (o_awready),
    .i_wvalid     (i_wvalid),
    .i_wdata      (i_wdata),
    .i_wstrb      (i_wstrb),
    .o_wready     (o_wready),
    .o_bvalid     (o_bvalid),
    .o_bresp      (o_bresp),
    .i_bready     (i_bready),
    .i_arvalid    (i_arvalid),
    .i_araddr     (i_araddr),
    .o_arready    (o_arready),
    .o_rvalid     (o_rvalid),
    .o_rdata      (o_rdata),
    .o_rresp      (o_rresp),
    .i_rready     (i_rready),
    .o_reg_addr   (reg_addr),
    .o_wr_req     (wr_req),
    .o_wr         (wr),
    .i_wr_ack_stb (wr_ack_stb),
    .i_wr_invalid (wr_invalid),
    .o_rd_req     (rd_req),
    .i_rd_ack_stb (rd_ack_stb),
    .i_rd         (rd)
  );

  reg_bank bank0 (
    .clk          (clk),
    .rst          (rst),
    .i_reg_addr   (reg_addr),
    .i_wr_req     (wr_req),
    .i_wr         (wr),
    .i_rd_req     (rd_req),
    .o_wr_ack_stb (wr_ack_stb),
    .o_wr_invalid (wr_invalid),
    .o_rd_ack_stb (rd_ack_stb),
    .o_rd         (rd)
  );

endmodule

//--- hw/reg_bank.sv
/*
  Six RW registers at 0x00..0x14 plus a read-only ID at 0x18.
  Every request is acked exactly ACK_DELAY cycles after its level rises.
  Unaligned or out-of-map accesses are flagged invalid, and such reads return 0.
  Writes to the ID address are dropped but not flagged.
*/
module reg_bank (
  input  logic                 clk,
  input  logic                 rst,

  input  axil_pkg::addr_t      i_reg_addr,
  input  logic                 i_wr_req,
  input  axil_pkg::reg_wr_t    i_wr,
  input  logic                 i_rd_req,

  output logic                 o_wr_ack_stb,
  output logic                 o_wr_invalid,
  output logic                 o_rd_ack_stb,
  output axil_pkg::reg_rd_t    o_rd
);

  import axil_pkg::*;

  data_t                regs [NUM_RW_REGS];
  logic [ACK_CNT_W-1:0] ack_cnt;

  logic                 req_any;
  logic                 ack_due;
  logic                 addr_ok;
  logic                 is_id;
  logic [IDX_W-1:0]     reg_idx;
  data_t                rd_value;

  assign req_any = i_wr_req || i_rd_req;

  // Last cycle before the ack, ack itself is registered
  assign ack_due = req_any && (ack_cnt == ACK_CNT_W'(ACK_DELAY - 1));

  // Word aligned and inside the map
  assign addr_ok = (i_reg_addr[1:0] == 2'b00) && (i_reg_addr < MAP_END);
  assign is_id   = (i_reg_addr == ID_ADDR);
  assign reg_idx = i_reg_addr[IDX_W+1:2];

  // Read mux
  always_comb begin
    rd_value = '0;
    if (addr_ok) begin
      if (is_id) begin
        rd_value = ID_VALUE;
      end else begin
        rd_value = regs[reg_idx];
      end
    end
  end

  // Delay counter and ack strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_cnt      <= '0;
      o_wr_ack_stb <= 1'b0;
      o_rd_ack_stb <= 1'b0;
    end else begin
      o_wr_ack_stb <= ack_due && i_wr_req;
      o_rd_ack_stb <= ack_due && i_rd_req;
      if (!req_any) begin
        ack_cnt <= '0;
      end else if (ack_cnt != ACK_CNT_W'(ACK_DELAY)) begin
        // Saturate so one request gives one ack
        ack_cnt <= ack_cnt + 1'b1;
      end
    end
  end

  // Register file, new value visible in the ack cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_RW_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ack_due && i_wr_req && addr_ok && !is_id) begin
      // Byte merge under strobe
      for (int b = 0; b < STRB_W; b++) begin
        if (i_wr.strb[b]) begin
          regs[reg_idx][8*b +: 8] <= i_wr.data[8*b +: 8];
        end
      end
    end
  end

  // Result and flag, valid with the ack strobe
  always_ff @(posedge clk) begin
    if (ack_due) begin
      o_wr_invalid <= !addr_ok;
      o_rd.data    <= rd_value;
      o_rd.invalid <= !addr_ok;
    end
  end

  // Bridge serves one transaction at a time
  a_one_req: assert property (@(posedge clk) disable iff (rst)
    !(i_wr_req && i_rd_req));

endmodule

//--- hw/axil_slave.sv
/*
  AXI4-Lite slave bridging to a strobe-based user register interface.
  One transaction at a time, AW wins over AR when both arrive together.
  No IDs, bursts or protection. Responses are OKAY or DECERR only.
*/
module axil_slave (
  input  logic                 clk,
  input  logic                 rst,

  // Write address channel
  input  logic                 i_awvalid,
  input  axil_pkg::addr_t      i_awaddr,
  output logic                 o_awready,

  // Write data channel
  input  logic                 i_wvalid,
  input  axil_pkg::data_t      i_wdata,
  input  axil_pkg::strb_t      i_wstrb,
  output logic                 o_wready,

  // Write response channel
  output logic                 o_bvalid,
  output axil_pkg::resp_t      o_bresp,
  input  logic                 i_bready,

  // Read address channel
  input  logic                 i_arvalid,
  input  axil_pkg::addr_t      i_araddr,
  output logic                 o_arready,

  // Read data channel
  output logic                 o_rvalid,
  output axil_pkg::data_t      o_rdata,
  output axil_pkg::resp_t      o_rresp,
  input  logic                 i_rready,

  // User register side
  output axil_pkg::addr_t      o_reg_addr,
  output logic                 o_wr_req,
  output axil_pkg::reg_wr_t    o_wr,
  input  logic                 i_wr_ack_stb,
  input  logic                 i_wr_invalid,
  output logic                 o_rd_req,
  input  logic                 i_rd_ack_stb,
  input  axil_pkg::reg_rd_t    i_rd
);

  import axil_pkg::*;

  slave_state_t state;

  logic aw_hs;
  logic ar_hs;
  logic w_hs;
  logic wr_done;
  logic rd_done;

  // Handshake qualifiers
  assign aw_hs   = (state == IDLE) && i_awvalid && o_awready;
  // Write has priority in the same cycle
  assign ar_hs   = (state == IDLE) && i_arvalid && o_arready && !aw_hs;
  assign w_hs    = (state == RECV_WDATA) && i_wvalid && o_wready;
  assign wr_done = (state == WR_WAIT_USER) && i_wr_ack_stb;
  assign rd_done = (state == RD_WAIT_USER) && i_rd_ack_stb;

  // Control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      o_awready <= 1'b0;
      o_arready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
      o_rvalid  <= 1'b0;
      o_wr_req  <= 1'b0;
      o_rd_req  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Ready for a new address one cycle after entering
          o_awready <= 1'b1;
          o_arready <= 1'b1;
          if (aw_hs) begin
            o_awready <= 1'b0;
            o_arready <= 1'b0;
            o_wready  <= 1'b1;
            state     <= RECV_WDATA;
          end else if (ar_hs) begin
            o_awready <= 1'b0;
            o_arready <= 1'b0;
            o_rd_req  <= 1'b1;
            state     <= RD_WAIT_USER;
          end
        end
        RECV_WDATA: begin
          if (w_hs) begin
            o_wready <= 1'b0;
            o_wr_req <= 1'b1;
            state    <= WR_WAIT_USER;
          end
        end
        WR_WAIT_USER: begin
          // Bank acks after its own fixed delay
          if (wr_done) begin
            o_wr_req <= 1'b0;
            o_bvalid <= 1'b1;
            state    <= SEND_BRESP;
          end
        end
        SEND_BRESP: begin
          if (i_bready) begin
            o_bvalid <= 1'b0;
            state    <= IDLE;
          end
        end
        RD_WAIT_USER: begin
          if (rd_done) begin
            o_rd_req <= 1'b0;
            o_rvalid <= 1'b1;
            state    <= SEND_RDATA;
          end
        end
        SEND_RDATA: begin
          if (i_rready) begin
            o_rvalid <= 1'b0;
            state    <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Payload, held stable across each transaction
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      o_reg_addr <= i_awaddr;
      o_wr.addr  <= i_awaddr;
    end else if (ar_hs) begin
      o_reg_addr <= i_araddr;
    end
    if (w_hs) begin
      o_wr.data <= i_wdata;
      o_wr.strb <= i_wstrb;
    end
    // Invalid flag only matters on the ack cycle
    if (wr_done) begin
      o_bresp <= i_wr_invalid ? RESP_DECERR : RESP_OKAY;
    end
    if (rd_done) begin
      o_rdata <= i_rd.data;
      o_rresp <= i_rd.invalid ? RESP_DECERR : RESP_OKAY;
    end
  end

  // Only one response channel active at a time
  a_one_resp: assert property (@(posedge clk) disable iff (rst)
    !(o_bvalid && o_rvalid));

  // B held with its payload until accepted
  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

  // R held with its payload until accepted
  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

//--- hw/axil_pkg.sv
/*
  Widths, register map and user-side types shared by the AXI4-Lite register block.
  Widths are fixed at 32 bits and are not meant to be changed.
  Register map covers 0x00..0x18. Every other address is decoded as invalid.
*/
package axil_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [1:0]        resp_t;

  // AXI response codes, SLVERR not used
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // Register map, one 32-bit word per register
  localparam int    NUM_RW_REGS = 6;
  localparam addr_t ID_ADDR     = 32'h0000_0018;
  // First address past the map
  localparam addr_t MAP_END     = 32'h0000_001C;
  localparam data_t ID_VALUE    = 32'h4158_4C01;

  // Word index covers the RW registers plus the ID slot
  localparam int IDX_W = $clog2(NUM_RW_REGS + 1);

  // Request to acknowledge delay in the bank, in cycles
  localparam int ACK_DELAY = 3;
  localparam int ACK_CNT_W = $clog2(ACK_DELAY + 1);

  // Write request, bridge to bank (68 bits)
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } reg_wr_t;

  // Read result, bank to bridge (33 bits)
  typedef struct packed {
    data_t data;
    logic  invalid;
  } reg_rd_t;

  // Bridge FSM
  typedef enum logic [2:0] {
    IDLE,
    RECV_WDATA,
    WR_WAIT_USER,
    SEND_BRESP,
    RD_WAIT_USER,
    SEND_RDATA
  } slave_state_t;

endpackage
